// ==== logic/bitmap_arbiter.sv ====
// bitmap arbiter, round-robin ownership between two clients and a mux of the owner's update
`timescale 1ns/1ps
`default_nettype none

module bitmap_arbiter (
    input  wire             clk,
    input  wire             arst_n,
    bitmap_if.arbiter       cl_a,
    bitmap_if.arbiter       cl_b,
    output logic            upd_set,
    output logic            upd_clr,
    output slot_pkg::slot_t upd_slot
);

    logic own_a;
    logic own_b;
    logic last_b;                                   // b was served last
    logic held;
    logic pick_b;

    assign held   = (own_a && cl_a.req) || (own_b && cl_b.req);
    assign pick_b = (cl_a.req && cl_b.req) ? !last_b : cl_b.req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            own_a  <= 1'b0;
            own_b  <= 1'b0;
            last_b <= 1'b0;
        end else if (!held) begin
            // owner released or none, hand over in the same edge
            own_a <= cl_a.req && !pick_b;
            own_b <= cl_b.req && pick_b;
            if (cl_a.req || cl_b.req) begin
                last_b <= pick_b;
            end
        end
    end

    assign cl_a.gnt = own_a;
    assign cl_b.gnt = own_b;

    always_comb begin
        if (own_b) begin
            upd_set  = cl_b.set;
            upd_clr  = cl_b.clr;
            upd_slot = cl_b.slot;
        end else begin
            upd_set  = own_a && cl_a.set;           // nothing passes without an owner
            upd_clr  = own_a && cl_a.clr;
            upd_slot = cl_a.slot;
        end
    end

endmodule

`default_nettype wire

// ==== logic/bitmap_if.sv ====
// one client's request, grant and update path to the shared busy bitmap
`timescale 1ns/1ps
`default_nettype none

interface bitmap_if;

    logic            req;                           // client wants the bitmap
    logic            gnt;                           // arbiter hands it over
    slot_pkg::busy_t busy;                          // current bitmap, fanned out by the top
    logic            set;                           // one-cycle mark busy
    logic            clr;                           // one-cycle mark free
    slot_pkg::slot_t slot;

    modport client (
        output req,
        output set,
        output clr,
        output slot,
        input  gnt,
        input  busy
    );

    modport arbiter (
        input  req,
        input  set,
        input  clr,
        input  slot,
        output gnt
    );

endinterface

`default_nettype wire

// ==== logic/slot_alloc_top.sv ====
// slot allocator top, two command clients sharing one busy bitmap through an arbiter
`timescale 1ns/1ps
`default_nettype none

module slot_alloc_top #(
    parameter bit a_search_high = 1'b1,             // a takes from the top
    parameter bit b_search_high = 1'b0              // b takes from the bottom
) (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     a_req,
    input  wire slot_pkg::slot_op_t a_op,
    input  wire slot_pkg::slot_t    a_slot_in,
    output logic                    a_ack,
    output slot_pkg::slot_t         a_slot_out,
    input  wire                     b_req,
    input  wire slot_pkg::slot_op_t b_op,
    input  wire slot_pkg::slot_t    b_slot_in,
    output logic                    b_ack,
    output slot_pkg::slot_t         b_slot_out
);

    bitmap_if if_a ();
    bitmap_if if_b ();

    logic            upd_set;
    logic            upd_clr;
    slot_pkg::slot_t upd_slot;
    slot_pkg::busy_t busy;

    assign if_a.busy = busy;
    assign if_b.busy = busy;

    slot_client #(.search_high(a_search_high)) u_client_a (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_req    (a_req),
        .cmd_op     (a_op),
        .cmd_slot   (a_slot_in),
        .cmd_ack    (a_ack),
        .cmd_result (a_slot_out),
        .bus        (if_a.client)
    );

    slot_client #(.search_high(b_search_high)) u_client_b (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_req    (b_req),
        .cmd_op     (b_op),
        .cmd_slot   (b_slot_in),
        .cmd_ack    (b_ack),
        .cmd_result (b_slot_out),
        .bus        (if_b.client)
    );

    bitmap_arbiter u_arbiter (
        .clk      (clk),
        .arst_n   (arst_n),
        .cl_a     (if_a.arbiter),
        .cl_b     (if_b.arbiter),
        .upd_set  (upd_set),
        .upd_clr  (upd_clr),
        .upd_slot (upd_slot)
    );

    slot_bitmap u_bitmap (
        .clk      (clk),
        .arst_n   (arst_n),
        .upd_set  (upd_set),
        .upd_clr  (upd_clr),
        .upd_slot (upd_slot),
        .busy     (busy)
    );

endmodule

`default_nettype wire

// ==== logic/slot_bitmap.sv ====
// busy bitmap register, sets or clears one slot per cycle
`timescale 1ns/1ps
`default_nettype none

module slot_bitmap (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  upd_set,
    input  wire                  upd_clr,
    input  wire slot_pkg::slot_t upd_slot,
    output slot_pkg::busy_t      busy
);

    slot_pkg::busy_t mask;

    // slots past the top shift out and leave the mask empty
    assign mask = slot_pkg::busy_t'(1) << upd_slot;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else if (upd_set) begin
            busy <= busy | mask;
        end else if (upd_clr) begin
            busy <= busy & ~mask;
        end
    end

endmodule

`default_nettype wire

// ==== logic/slot_client.sv ====
// slot client, four-phase command front end that searches the bitmap and commits one update
`timescale 1ns/1ps
`default_nettype none

module slot_client #(
    parameter bit search_high = 1'b1                // 1 takes the highest free slot, 0 the lowest
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  cmd_req,
    input  wire slot_pkg::slot_op_t cmd_op,
    input  wire slot_pkg::slot_t cmd_slot,
    output logic                 cmd_ack,
    output slot_pkg::slot_t      cmd_result,
    bitmap_if.client             bus
);

    typedef enum logic [1:0] {
        idle,
        wait_gnt,
        done,
        drop
    } state_t;

    state_t          state;
    slot_pkg::slot_t scan_slot;
    slot_pkg::slot_t result_d;
    logic            commit;

    generate
        if (search_high) begin : g_high
            ffz96 u_scan (.i(bus.busy), .o(scan_slot));
        end else begin : g_low
            flz96 u_scan (.i(bus.busy), .o(scan_slot));
        end
    endgenerate

    assign commit = (state == wait_gnt) && bus.gnt; // only cycle that may touch the bitmap

    always_comb begin
        bus.set  = 1'b0;
        bus.clr  = 1'b0;
        bus.slot = cmd_slot;
        result_d = slot_pkg::slot_none;
        if (cmd_op == slot_pkg::op_alloc) begin
            if (scan_slot != '1) begin              // all ones = bitmap full
                result_d = scan_slot;
                bus.slot = scan_slot;
                bus.set  = commit;
            end
        end else if (cmd_slot < slot_pkg::slot_count) begin
            result_d = cmd_slot;                    // echo the freed slot
            bus.clr  = commit;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            bus.req    <= 1'b0;
            cmd_ack    <= 1'b0;
            cmd_result <= slot_pkg::slot_none;
        end else begin
            case (state)
                idle: begin
                    if (cmd_req) begin
                        state   <= wait_gnt;
                        bus.req <= 1'b1;
                    end
                end
                wait_gnt: begin
                    if (bus.gnt) begin
                        state      <= done;
                        bus.req    <= 1'b0;
                        cmd_ack    <= 1'b1;
                        cmd_result <= result_d;
                    end
                end
                done: begin
                    if (!cmd_req) begin             // held req keeps ack and result
                        state   <= drop;
                        cmd_ack <= 1'b0;
                    end
                end
                drop: begin
                    if (!bus.gnt) begin             // wait out the trailing grant
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/slot_pkg.sv ====
// slot allocator shared widths, none code and command opcode
`default_nettype none

package slot_pkg;

    localparam int slot_count = 96;                 // resource slots in the busy bitmap
    localparam int slot_w     = 7;                  // bits in a slot number

    typedef logic [slot_w-1:0]     slot_t;
    typedef logic [slot_count-1:0] busy_t;          // set bit = slot taken

    // all ones, the same code the zero scan trees give on a miss
    localparam slot_t slot_none = 7'd127;

    typedef enum logic {
        op_alloc = 1'b0,
        op_free  = 1'b1
    } slot_op_t;

endpackage

`default_nettype wire

// ==== logic/zero_scan.sv ====
// zero scan trees, ffz finds the highest zero bit and flz the lowest, all ones on a miss
`timescale 1ns/1ps
`default_nettype none

module ffz6 (
    input  wire  [5:0] i,
    output logic [2:0] o
);
    always_comb begin
        casez (i)
            6'b0?????: o = 3'd5;
            6'b10????: o = 3'd4;
            6'b110???: o = 3'd3;
            6'b1110??: o = 3'd2;
            6'b11110?: o = 3'd1;
            6'b111110: o = 3'd0;
            default:   o = 3'd7;                    // no zero in this leaf
        endcase
    end
endmodule

module ffz12 (
    input  wire  [11:0] i,
    output logic [3:0]  o
);
    logic [2:0] o_hi;
    logic [2:0] o_lo;

    ffz6 u_hi (.i(i[11:6]), .o(o_hi));
    ffz6 u_lo (.i(i[5:0]),  .o(o_lo));

    always_comb begin
        if (o_hi != 3'd7) begin
            o = 4'd6 + {1'b0, o_hi};                // upper half wins
        end else if (o_lo != 3'd7) begin
            o = {1'b0, o_lo};
        end else begin
            o = 4'd15;
        end
    end
endmodule

module ffz24 (
    input  wire  [23:0] i,
    output logic [4:0]  o
);
    logic [3:0] o_hi;
    logic [3:0] o_lo;

    ffz12 u_hi (.i(i[23:12]), .o(o_hi));
    ffz12 u_lo (.i(i[11:0]),  .o(o_lo));

    always_comb begin
        if (o_hi != 4'd15) begin
            o = 5'd12 + {1'b0, o_hi};
        end else if (o_lo != 4'd15) begin
            o = {1'b0, o_lo};
        end else begin
            o = 5'd31;
        end
    end
endmodule

module ffz48 (
    input  wire  [47:0] i,
    output logic [5:0]  o
);
    logic [4:0] o_hi;
    logic [4:0] o_lo;

    ffz24 u_hi (.i(i[47:24]), .o(o_hi));
    ffz24 u_lo (.i(i[23:0]),  .o(o_lo));

    always_comb begin
        if (o_hi != 5'd31) begin
            o = 6'd24 + {1'b0, o_hi};
        end else if (o_lo != 5'd31) begin
            o = {1'b0, o_lo};
        end else begin
            o = 6'd63;
        end
    end
endmodule

module ffz96 (
    input  wire  [95:0] i,
    output logic [6:0]  o
);
    logic [5:0] o_hi;
    logic [5:0] o_lo;

    ffz48 u_hi (.i(i[95:48]), .o(o_hi));
    ffz48 u_lo (.i(i[47:0]),  .o(o_lo));

    always_comb begin
        if (o_hi != 6'd63) begin
            o = 7'd48 + {1'b0, o_hi};
        end else if (o_lo != 6'd63) begin
            o = {1'b0, o_lo};
        end else begin
            o = 7'd127;
        end
    end
endmodule

module flz6 (
    input  wire  [5:0] i,
    output logic [2:0] o
);
    always_comb begin
        casez (i)
            6'b?????0: o = 3'd0;
            6'b????01: o = 3'd1;
            6'b???011: o = 3'd2;
            6'b??0111: o = 3'd3;
            6'b?01111: o = 3'd4;
            6'b011111: o = 3'd5;
            default:   o = 3'd7;
        endcase
    end
endmodule

module flz12 (
    input  wire  [11:0] i,
    output logic [3:0]  o
);
    logic [2:0] o_hi;
    logic [2:0] o_lo;

    flz6 u_hi (.i(i[11:6]), .o(o_hi));
    flz6 u_lo (.i(i[5:0]),  .o(o_lo));

    always_comb begin
        if (o_lo != 3'd7) begin
            o = {1'b0, o_lo};                       // lower half wins
        end else if (o_hi != 3'd7) begin
            o = 4'd6 + {1'b0, o_hi};
        end else begin
            o = 4'd15;
        end
    end
endmodule

module flz24 (
    input  wire  [23:0] i,
    output logic [4:0]  o
);
    logic [3:0] o_hi;
    logic [3:0] o_lo;

    flz12 u_hi (.i(i[23:12]), .o(o_hi));
    flz12 u_lo (.i(i[11:0]),  .o(o_lo));

    always_comb begin
        if (o_lo != 4'd15) begin
            o = {1'b0, o_lo};
        end else if (o_hi != 4'd15) begin
            o = 5'd12 + {1'b0, o_hi};
        end else begin
            o = 5'd31;
        end
    end
endmodule

module flz48 (
    input  wire  [47:0] i,
    output logic [5:0]  o
);
    logic [4:0] o_hi;
    logic [4:0] o_lo;

    flz24 u_hi (.i(i[47:24]), .o(o_hi));
    flz24 u_lo (.i(i[23:0]),  .o(o_lo));

    always_comb begin
        if (o_lo != 5'd31) begin
            o = {1'b0, o_lo};
        end else if (o_hi != 5'd31) begin
            o = 6'd24 + {1'b0, o_hi};
        end else begin
            o = 6'd63;
        end
    end
endmodule

module flz96 (
    input  wire  [95:0] i,
    output logic [6:0]  o
);
    logic [5:0] o_hi;
    logic [5:0] o_lo;

    flz48 u_hi (.i(i[95:48]), .o(o_hi));
    flz48 u_lo (.i(i[47:0]),  .o(o_lo));

    always_comb begin
        if (o_lo != 6'd63) begin
            o = {1'b0, o_lo};
        end else if (o_hi != 6'd63) begin
            o = 7'd48 + {1'b0, o_hi};
        end else begin
            o = 7'd127;
        end
    end
endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the slot allocator testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module slot_alloc_tb -f src.f
./obj_dir/Vslot_alloc_tb | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== src.f ====
logic/slot_pkg.sv
logic/bitmap_if.sv
logic/zero_scan.sv
logic/slot_client.sv
logic/bitmap_arbiter.sv
logic/slot_bitmap.sv
logic/slot_alloc_top.sv
test/slot_alloc_tb.sv

// ==== test/slot_alloc_tb.sv ====
// slot allocator testbench that runs the stimulus commands on both clients and checks results
`timescale 1ns/1ps
`default_nettype none

module slot_alloc_tb;

    localparam int line_w    = 7;                   // bytes per stimulus line
    localparam int max_lines = 64;
    localparam int ack_limit = 40;                  // cycles allowed per handshake phase

    logic               clk;
    logic               arst_n;
    logic               a_req;
    slot_pkg::slot_op_t a_op;
    slot_pkg::slot_t    a_slot_in;
    logic               a_ack;
    slot_pkg::slot_t    a_slot_out;
    logic               b_req;
    slot_pkg::slot_op_t b_op;
    slot_pkg::slot_t    b_slot_in;
    logic               b_ack;
    slot_pkg::slot_t    b_slot_out;

    logic [7:0] stim [0:line_w*max_lines-1];
    int         errors;                             // errors in the running test
    int         tests_passed;
    int         tests_failed;
    int         watchdog_cycles;

    slot_alloc_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .a_req      (a_req),
        .a_op       (a_op),
        .a_slot_in  (a_slot_in),
        .a_ack      (a_ack),
        .a_slot_out (a_slot_out),
        .b_req      (b_req),
        .b_op       (b_op),
        .b_slot_in  (b_slot_in),
        .b_ack      (b_ack),
        .b_slot_out (b_slot_out)
    );

    always #50 clk = ~clk;

    task automatic check_slot(input string name, input slot_pkg::slot_t expected,
                              input slot_pkg::slot_t actual);
        if (actual !== expected) begin
            $display("FAILED %0d ns %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %0d ns %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %0d ns %s", $time, msg);
        errors++;
    endtask

    task automatic close_test(input int test_no);
        if (errors == 0) begin
            tests_passed++;
            $display("test %0d done, no errors", test_no);
        end else begin
            tests_failed++;
            $display("test %0d done, %0d errors", test_no, errors);
        end
        errors = 0;
    endtask

    // one four-phase handshake on a, b or both that starts 1 ns after a rising edge
    task automatic run_command(input int client, input slot_pkg::slot_op_t op,
                               input slot_pkg::slot_t slot, input slot_pkg::slot_t exp_a,
                               input slot_pkg::slot_t exp_b);
        bit              need_a;
        bit              need_b;
        bit              got_a;
        bit              got_b;
        int              cycles;
        slot_pkg::slot_t res_a;
        slot_pkg::slot_t res_b;

        need_a = (client != 1);
        need_b = (client != 0);
        got_a  = !need_a;
        got_b  = !need_b;
        res_a  = slot_pkg::slot_none;
        res_b  = slot_pkg::slot_none;
        cycles = 0;
        if (need_a) begin
            a_op      = op;
            a_slot_in = slot;
            a_req     = 1'b1;
        end
        if (need_b) begin
            b_op      = op;
            b_slot_in = slot;
            b_req     = 1'b1;
        end
        while (!(got_a && got_b) && cycles < ack_limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!got_a && a_ack) begin
                got_a = 1'b1;
                res_a = a_slot_out;
            end
            if (!got_b && b_ack) begin
                got_b = 1'b1;
                res_b = b_slot_out;
            end
        end
        if (!got_a) report_error("client a never raised its ack");
        if (!got_b) report_error("client b never raised its ack");

        // req stays high one more cycle and ack and result must hold
        @(posedge clk);
        #1;
        if (need_a && got_a) begin
            check_bit("a_ack", 1'b1, a_ack);
            check_slot("a_slot_out held", res_a, a_slot_out);
            check_slot("a_slot_out", exp_a, res_a);
        end
        if (need_b && got_b) begin
            check_bit("b_ack", 1'b1, b_ack);
            check_slot("b_slot_out held", res_b, b_slot_out);
            check_slot("b_slot_out", exp_b, res_b);
        end
        if (need_a && need_b && got_a && got_b && res_a != slot_pkg::slot_none
                && res_a == res_b) begin
            report_error("both clients were handed the same slot");
        end

        a_req  = 1'b0;
        b_req  = 1'b0;
        cycles = 0;
        while ((a_ack || b_ack) && cycles < ack_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (a_ack || b_ack) report_error("ack stayed high after req was dropped");
    endtask

    initial begin
        int              base;
        int              current;
        int              client;
        int              count;
        int              total;
        int              gap;
        slot_pkg::slot_op_t op;
        slot_pkg::slot_t slot;
        slot_pkg::slot_t exp_a;
        slot_pkg::slot_t exp_b;
        slot_pkg::slot_t ea;
        slot_pkg::slot_t eb;

        void'($urandom(32'hf2ed2c77));
        clk          = 1'b0;
        arst_n       = 1'b0;
        a_req        = 1'b0;
        a_op         = slot_pkg::op_alloc;
        a_slot_in    = '0;
        b_req        = 1'b0;
        b_op         = slot_pkg::op_alloc;
        b_slot_in    = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;

        $readmemh("test/slot_stimulus.txt", stim);
        total = 0;
        base  = 0;
        while (base < line_w*max_lines && stim[base] !== 8'h00 && !$isunknown(stim[base])) begin
            total += int'(stim[base + 4]);
            base  += line_w;
        end
        watchdog_cycles = (total + 4) * 20;

        repeat (2) @(posedge clk);
        #1;
        arst_n  = 1'b1;
        current = 1;                                // reset checks count toward test 1
        check_bit("a_ack", 1'b0, a_ack);
        check_bit("b_ack", 1'b0, b_ack);
        check_slot("a_slot_out", slot_pkg::slot_none, a_slot_out);
        check_slot("b_slot_out", slot_pkg::slot_none, b_slot_out);
        if (total == 0) report_error("no commands found in the stimulus file");

        base = 0;
        while (base < line_w*max_lines && stim[base] !== 8'h00 && !$isunknown(stim[base])) begin
            if (int'(stim[base]) != current) begin
                close_test(current);
                current = int'(stim[base]);
            end
            client = int'(stim[base + 1]);
            op     = slot_pkg::slot_op_t'(stim[base + 2][0]);
            slot   = stim[base + 3][6:0];
            count  = int'(stim[base + 4]);
            exp_a  = stim[base + 5][6:0];
            exp_b  = stim[base + 6][6:0];
            for (int k = 0; k < count; k++) begin
                ea = exp_a;
                eb = exp_b;
                if (op == slot_pkg::op_alloc) begin     // a walks down and b walks up
                    if (exp_a != slot_pkg::slot_none) ea = slot_pkg::slot_t'(int'(exp_a) - k);
                    if (exp_b != slot_pkg::slot_none) eb = slot_pkg::slot_t'(int'(exp_b) + k);
                end
                run_command(client, op, slot, ea, eb);
                gap = int'($urandom % 4);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            base += line_w;
        end
        close_test(current);

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/slot_stimulus.txt ====
// columns, all hex: test client(0 a, 1 b, 2 both) op(0 alloc, 1 free) slot count exp_a exp_b
// a repeated alloc steps a's result down and b's up by one each time, a test of 00 ends the list
01 00 00 00 01 5f 7f
01 01 00 00 01 7f 00
02 00 00 00 03 5e 7f
02 01 00 00 03 7f 01
03 00 01 5e 01 5e 7f
03 00 00 00 01 5e 7f
03 00 01 64 01 7f 7f
03 00 00 00 01 5b 7f
03 01 01 64 01 7f 7f
03 01 00 00 01 7f 04
04 02 00 00 03 5a 05
05 01 00 00 28 7f 08
05 00 00 00 28 57 7f
05 00 00 00 01 7f 7f
05 01 00 00 01 7f 7f
05 02 00 00 01 7f 7f
05 00 01 28 01 28 7f
05 01 00 00 01 7f 28
00 00 00 00 00 00 00
